// ==== dk_bus_top.f ====
+incdir+hw
hw/dk_bus_pkg.sv
hw/dk_dma_if.sv
hw/dk_adec.sv
hw/dk_dpram.sv
hw/dk_sprite_dma.sv
hw/dk_inport.sv
hw/dk_bus_top.sv
verif/dk_bus_asserts.sv
verif/dk_bus_tb.sv

// ==== hw/dk_adec.sv ====
/*
  CPU address decoder. Pulses the RAM and input selects, remaps ROM pages
  for the junior board, holds the control latch and NMI flop, triggers the
  sprite DMA and returns read data one cycle after the read strobe.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_adec
	import dk_bus_pkg::*;
(
	input  logic        clk_24576m,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	input  logic        v_blank,
	input  logic        dkjr,
	input  logic [7:0]  rom_data,
	input  logic [7:0]  ram1_rdata,
	input  logic [7:0]  ram2_rdata,
	input  logic [7:0]  ram3_rdata,
	input  logic [7:0]  in_rdata,
	output logic [15:0] rom_addr,
	output logic        ram1_ce,
	output logic        ram2_ce,
	output logic        ram3_ce,
	output logic        ram_we,
	output logic        in_rd,
	output logic [1:0]  in_sel,
	output logic        dma_start,
	output logic        nmi_n,
	output logic        flip_n,
	output logic        two_player_sel,
	output logic [1:0]  pal_bank,
	output logic [7:0]  cpu_rdata
);

	// Region compare masks
	localparam logic [15:0] ram_mask   = 16'hFC00;
	localparam logic [15:0] in_mask    = 16'hFF80;
	localparam logic [15:0] latch_mask = 16'hFFF8;

	cpu_addr_u  addr_v;
	cpu_addr_u  rom_v;
	logic       access;
	logic       rom_hit, ram1_hit, ram2_hit, ram3_hit;
	logic       sw1_hit, sw2_hit, sw3_hit, dip_hit, in_hit;
	logic       latch_wr;
	logic [7:0] latch;
	logic [7:0] latch_nxt;
	logic       vblank_q;
	logic       nmi_ff;
	logic       rd_rom_q, rd_ram1_q, rd_ram2_q, rd_ram3_q, rd_in_q;
	logic [7:0] rom_q;

	// ================================================
	// Region decode
	// ================================================
	assign addr_v.raw = cpu_addr;
	assign access     = cpu_rd | cpu_wr;

	assign rom_hit  = addr_v.raw <= `DK_ROM_TOP;
	assign ram1_hit = (addr_v.raw & ram_mask) == `DK_RAM1_BASE;
	assign ram2_hit = (addr_v.raw & ram_mask) == `DK_RAM2_BASE;
	assign ram3_hit = (addr_v.raw & ram_mask) == `DK_RAM3_BASE;
	// Inputs sit in four 128-byte windows
	assign sw1_hit  = (addr_v.raw & in_mask) == `DK_IN_SW1;
	assign sw2_hit  = (addr_v.raw & in_mask) == `DK_IN_SW2;
	assign sw3_hit  = (addr_v.raw & in_mask) == `DK_IN_SW3;
	assign dip_hit  = (addr_v.raw & in_mask) == `DK_IN_DIP;
	assign in_hit   = sw1_hit | sw2_hit | sw3_hit | dip_hit;

	// One-cycle selects, same cycle as the strobe
	assign ram1_ce = access & ram1_hit;
	assign ram2_ce = access & ram2_hit;
	assign ram3_ce = access & ram3_hit;
	assign ram_we  = cpu_wr;
	assign in_rd   = cpu_rd & in_hit;
	// 0 p1, 1 p2, 2 system, 3 DIP
	assign in_sel  = {sw3_hit | dip_hit, sw2_hit | dip_hit};

	// ================================================
	// Junior board ROM remap
	// ================================================
	// Page swap only, offset rides through untouched
	always_comb begin
		rom_v = addr_v;
		if (dkjr) begin
			case (addr_v.rom_page.page)
				5'h02: rom_v.rom_page.page = 5'h06;
				5'h03: rom_v.rom_page.page = 5'h0B;
				5'h05: rom_v.rom_page.page = 5'h09;
				5'h06: rom_v.rom_page.page = 5'h02;
				5'h07: rom_v.rom_page.page = 5'h03;
				5'h09: rom_v.rom_page.page = 5'h05;
				5'h0B: rom_v.rom_page.page = 5'h07;
				default: ;
			endcase
		end
	end
	assign rom_addr = rom_v.raw;

	// ================================================
	// Control latch and NMI
	// ================================================
	assign latch_wr = cpu_wr & ((addr_v.raw & latch_mask) == `DK_LATCH_BASE);

	// Bit-addressable, data bit 0 lands on the offset bit
	always_comb begin
		latch_nxt = latch;
		if (latch_wr)
			latch_nxt[addr_v.raw[2:0]] = cpu_wdata[0];
	end

	// Rising edge of the DMA bit
	assign dma_start = latch_nxt[`DK_LATCH_DMA] & ~latch[`DK_LATCH_DMA];

	always_ff @(posedge clk_24576m) begin
		if (reset) begin
			latch    <= 8'h00;
			vblank_q <= 1'b0;
			nmi_ff   <= 1'b0;
		end else begin
			latch    <= latch_nxt;
			vblank_q <= v_blank;
			// Clearing the enable also clears a pending NMI
			if (!latch_nxt[`DK_LATCH_NMI_EN])
				nmi_ff <= 1'b0;
			else if (v_blank && !vblank_q)
				nmi_ff <= 1'b1;
		end
	end

	assign nmi_n          = ~nmi_ff;
	assign flip_n         = ~latch[`DK_LATCH_FLIP];
	assign two_player_sel = latch[`DK_LATCH_2PSL];
	assign pal_bank       = latch[`DK_LATCH_PAL +: 2];

	// ================================================
	// Read data return
	// ================================================
	// Remember which source the read picked
	always_ff @(posedge clk_24576m) begin
		if (reset) begin
			rd_rom_q  <= 1'b0;
			rd_ram1_q <= 1'b0;
			rd_ram2_q <= 1'b0;
			rd_ram3_q <= 1'b0;
			rd_in_q   <= 1'b0;
		end else begin
			rd_rom_q  <= cpu_rd & rom_hit;
			rd_ram1_q <= cpu_rd & ram1_hit;
			rd_ram2_q <= cpu_rd & ram2_hit;
			rd_ram3_q <= cpu_rd & ram3_hit;
			rd_in_q   <= in_rd;
		end
	end

	// ROM answers combinationally, hold it for the return cycle
	always_ff @(posedge clk_24576m) begin
		if (cpu_rd && rom_hit)
			rom_q <= rom_data;
	end

	// Unmapped reads fall through to 00
	always_comb begin
		if (rd_rom_q)
			cpu_rdata = rom_q;
		else if (rd_ram1_q)
			cpu_rdata = ram1_rdata;
		else if (rd_ram2_q)
			cpu_rdata = ram2_rdata;
		else if (rd_ram3_q)
			cpu_rdata = ram3_rdata;
		else if (rd_in_q)
			cpu_rdata = in_rdata;
		else
			cpu_rdata = 8'h00;
	end

endmodule

// ==== hw/dk_bus_consts.svh ====
/*
  Memory map, control latch bit numbers and sprite DMA length for the
  CPU bus subsystem. Include wherever an address or latch bit is needed.
*/
`ifndef DK_BUS_CONSTS_SVH
`define DK_BUS_CONSTS_SVH

// ================================================
// CPU memory map
// ================================================
// Program ROM, 0000 up to here
`define DK_ROM_TOP      16'h5FFF
// Work RAMs, 1 KB each
`define DK_RAM1_BASE    16'h6000
`define DK_RAM2_BASE    16'h6400
`define DK_RAM3_BASE    16'h7000
// Input read windows
`define DK_IN_SW1       16'h7C00
`define DK_IN_SW2       16'h7C80
`define DK_IN_SW3       16'h7D00
`define DK_IN_DIP       16'h7D80
// Control latch, one bit per offset 0..7
`define DK_LATCH_BASE   16'h7D80

// Control latch bits
`define DK_LATCH_FLIP   2
`define DK_LATCH_2PSL   3
`define DK_LATCH_NMI_EN 4
`define DK_LATCH_DMA    5
// Low bit of the two-bit palette bank field
`define DK_LATCH_PAL    6

// Sprite copy, RAM3 offset 0 into object RAM offset 0
`define DK_DMA_LEN      384
`define DK_RAM_AW       10

`endif

// ==== hw/dk_bus_pkg.sv ====
/*
  Types shared by the bus decoder and the testbench reference model.
  Import where the CPU address has to be taken apart.
*/
package dk_bus_pkg;

	// ================================================
	// CPU address word
	// ================================================

	// ROM view of the address
	// Page is the 2 KB bank the junior board swaps around
	typedef struct packed {
		logic [4:0]  page;
		logic [10:0] offset;
	} rom_page_t;

	// One 16-bit word, two decodes
	// raw goes to the region compares
	// rom_page goes to the ROM remap
	typedef union packed {
		logic [15:0] raw;
		rom_page_t   rom_page;
	} cpu_addr_u;

endpackage

// ==== hw/dk_bus_top.sv ====
/*
  CPU bus subsystem top. Ties the decoder, the work and object RAMs, the
  sprite DMA and the input port to plain ports for the CPU model.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_bus_top (
	input  logic                  clk_24576m,
	input  logic                  reset,
	input  logic [15:0]           cpu_addr,
	input  logic [7:0]            cpu_wdata,
	input  logic                  cpu_rd,
	input  logic                  cpu_wr,
	input  logic                  bus_ack,
	input  logic                  v_blank,
	input  logic                  dkjr,
	input  logic [4:0]            sw_p1,
	input  logic [4:0]            sw_p2,
	input  logic [2:0]            sw_sys,
	input  logic [7:0]            dip_sw,
	input  logic [7:0]            rom_data,
	input  logic [`DK_RAM_AW-1:0] obj_addr,
	output logic [7:0]            cpu_rdata,
	output logic [15:0]           rom_addr,
	output logic                  bus_req,
	output logic                  nmi_n,
	output logic                  flip_n,
	output logic                  two_player_sel,
	output logic [1:0]            pal_bank,
	output logic [7:0]            obj_data
);

	logic       ram1_ce, ram2_ce, ram3_ce, ram_we;
	logic [7:0] ram1_rdata, ram2_rdata, ram3_rdata;
	logic       in_rd;
	logic [1:0] in_sel;
	logic [7:0] in_rdata;
	logic       dma_start;

	dk_dma_if dma_bus ();

	// ================================================
	// Decoder
	// ================================================
	dk_adec u_adec (
		.clk_24576m, .reset, .cpu_addr, .cpu_wdata, .cpu_rd, .cpu_wr,
		.v_blank, .dkjr, .rom_data, .ram1_rdata, .ram2_rdata, .ram3_rdata,
		.in_rdata, .rom_addr, .ram1_ce, .ram2_ce, .ram3_ce, .ram_we, .in_rd,
		.in_sel, .dma_start, .nmi_n, .flip_n, .two_player_sel, .pal_bank,
		.cpu_rdata
	);

	// ================================================
	// Work RAMs, CPU on port A
	// ================================================
	// Port B idle on RAM1 and RAM2
	dk_dpram u_ram1 (
		.clk_24576m, .addr_a(cpu_addr[9:0]), .wdata_a(cpu_wdata), .ce_a(ram1_ce),
		.we_a(ram_we), .rdata_a(ram1_rdata), .addr_b('0), .wdata_b(8'h00),
		.ce_b(1'b0), .we_b(1'b0), .rdata_b()
	);

	dk_dpram u_ram2 (
		.clk_24576m, .addr_a(cpu_addr[9:0]), .wdata_a(cpu_wdata), .ce_a(ram2_ce),
		.we_a(ram_we), .rdata_a(ram2_rdata), .addr_b('0), .wdata_b(8'h00),
		.ce_b(1'b0), .we_b(1'b0), .rdata_b()
	);

	// Sprite RAM, DMA reads port B
	dk_dpram u_ram3 (
		.clk_24576m, .addr_a(cpu_addr[9:0]), .wdata_a(cpu_wdata), .ce_a(ram3_ce),
		.we_a(ram_we), .rdata_a(ram3_rdata), .addr_b(dma_bus.src_addr),
		.wdata_b(8'h00), .ce_b(dma_bus.src_ce), .we_b(1'b0),
		.rdata_b(dma_bus.src_data)
	);

	// ================================================
	// Object RAM and sprite DMA
	// ================================================
	// DMA writes port A, video side reads port B every cycle
	dk_dpram u_objram (
		.clk_24576m, .addr_a(dma_bus.dst_addr), .wdata_a(dma_bus.dst_data),
		.ce_a(dma_bus.dst_we), .we_a(dma_bus.dst_we), .rdata_a(),
		.addr_b(obj_addr), .wdata_b(8'h00), .ce_b(1'b1), .we_b(1'b0),
		.rdata_b(obj_data)
	);

	dk_sprite_dma u_dma (
		.clk_24576m, .reset, .dma_start, .bus_ack, .bus_req, .dma(dma_bus)
	);

	// Switch and DIP port
	dk_inport u_inport (
		.clk_24576m, .in_rd, .in_sel, .sw_p1, .sw_p2, .sw_sys, .dip_sw, .in_rdata
	);

endmodule

// ==== hw/dk_dma_if.sv ====
/*
  Sprite DMA bus between the copier and its two RAM ports.
  Source side reads RAM3 port B, destination side writes object RAM port A.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

interface dk_dma_if;

	// Read side, RAM3 port B
	logic [`DK_RAM_AW-1:0] src_addr;
	logic                  src_ce;
	logic [7:0]            src_data;

	// Write side, object RAM port A
	logic [`DK_RAM_AW-1:0] dst_addr;
	logic [7:0]            dst_data;
	logic                  dst_we;

	modport dma (output src_addr, src_ce, dst_addr, dst_data, dst_we, input src_data);
	modport src_ram (input src_addr, src_ce, output src_data);
	modport dst_ram (input dst_addr, dst_data, dst_we);

endinterface

// ==== hw/dk_dpram.sv ====
/*
  True dual-port synchronous RAM, one clock. Each port reads or writes on
  its select and returns read data registered one cycle later.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_dpram #(
	parameter int aw = `DK_RAM_AW
) (
	input  logic          clk_24576m,
	// Port A
	input  logic [aw-1:0] addr_a,
	input  logic [7:0]    wdata_a,
	input  logic          ce_a,
	input  logic          we_a,
	output logic [7:0]    rdata_a,
	// Port B
	input  logic [aw-1:0] addr_b,
	input  logic [7:0]    wdata_b,
	input  logic          ce_b,
	input  logic          we_b,
	output logic [7:0]    rdata_b
);

	logic [7:0] mem [2**aw];

	// Both ports in one block, read before write on each
	always_ff @(posedge clk_24576m) begin
		if (ce_a) begin
			rdata_a <= mem[addr_a];
			if (we_a)
				mem[addr_a] <= wdata_a;
		end
		if (ce_b) begin
			rdata_b <= mem[addr_b];
			if (we_b)
				mem[addr_b] <= wdata_b;
		end
	end

endmodule

// ==== hw/dk_inport.sv ====
/*
  Player switch and DIP input port. Builds the four input bytes and
  registers the one picked by in_sel on in_rd.
*/
`timescale 1ns/1ns

module dk_inport (
	input  logic       clk_24576m,
	input  logic       in_rd,
	input  logic [1:0] in_sel,
	// Jump, down, up, left, right from bit 4 down
	input  logic [4:0] sw_p1,
	input  logic [4:0] sw_p2,
	// Coin, start 2, start 1
	input  logic [2:0] sw_sys,
	input  logic [7:0] dip_sw,
	output logic [7:0] in_rdata
);

	logic [7:0] byte_p1, byte_p2, byte_sys;

	assign byte_p1  = {3'b000, sw_p1};
	assign byte_p2  = {3'b000, sw_p2};
	// Coin on bit 7, starts on bits 3 and 2
	assign byte_sys = {sw_sys[2], 3'b000, sw_sys[1], sw_sys[0], 2'b00};

	always_ff @(posedge clk_24576m) begin
		if (in_rd) begin
			case (in_sel)
				2'd0: in_rdata <= byte_p1;
				2'd1: in_rdata <= byte_p2;
				2'd2: in_rdata <= byte_sys;
				default: in_rdata <= dip_sw;
			endcase
		end
	end

endmodule

// ==== hw/dk_sprite_dma.sv ====
/*
  Sprite DMA. Requests the CPU bus on dma_start, then copies DK_DMA_LEN
  bytes from RAM3 into object RAM, one read per cycle while bus_ack is high.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_sprite_dma (
	input  logic   clk_24576m,
	input  logic   reset,
	input  logic   dma_start,
	input  logic   bus_ack,
	output logic   bus_req,
	dk_dma_if.dma  dma
);

	localparam logic [`DK_RAM_AW-1:0] dma_len  = `DK_RAM_AW'(`DK_DMA_LEN);
	localparam logic [`DK_RAM_AW-1:0] dma_last = `DK_RAM_AW'(`DK_DMA_LEN - 1);

	logic                  rd_go;
	logic [`DK_RAM_AW-1:0] rd_cnt;
	logic [`DK_RAM_AW-1:0] rd_addr;
	logic                  rd_vld;
	logic [`DK_RAM_AW-1:0] wr_addr;
	logic                  wr_vld;

	// Issue a read only with the bus granted and bytes left
	assign rd_go = bus_req & bus_ack & (rd_cnt != dma_len);

	always_ff @(posedge clk_24576m) begin
		if (reset) begin
			bus_req <= 1'b0;
			rd_cnt  <= '0;
			rd_vld  <= 1'b0;
			wr_vld  <= 1'b0;
		end else begin
			rd_vld <= rd_go;
			wr_vld <= rd_vld;
			if (!bus_req) begin
				// Restart only from idle
				if (dma_start) begin
					bus_req <= 1'b1;
					rd_cnt  <= '0;
				end
			end else begin
				if (rd_go)
					rd_cnt <= rd_cnt + 1'b1;
				// Release after the final byte lands
				if (wr_vld && wr_addr == dma_last)
					bus_req <= 1'b0;
			end
		end
	end

	// Read address stage, then one-stage write register
	always_ff @(posedge clk_24576m) begin
		if (rd_go)
			rd_addr <= rd_cnt;
		wr_addr <= rd_addr;
	end

	assign dma.src_addr = rd_addr;
	assign dma.src_ce   = rd_vld;
	// Byte comes straight off the RAM3 output register
	assign dma.dst_addr = wr_addr;
	assign dma.dst_data = dma.src_data;
	assign dma.dst_we   = wr_vld;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus subsystem testbench with Verilator.
# The simulator exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f dk_bus_top.f \
	--top-module dk_bus_tb \
	--Mdir obj_dir \
	-o dk_bus_sim

# Assertion errors are counted and judged by the testbench at the end
./obj_dir/dk_bus_sim +verilator+error+limit+1000

// ==== verif/dk_bus_asserts.sv ====
/*
  Bus and sprite DMA rules, bound into the bus top. Covers the CPU
  strobes, the NMI enable and the bus request over one copy.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_bus_asserts (
	input logic                  clk_24576m,
	input logic                  reset,
	input logic                  cpu_rd,
	input logic                  cpu_wr,
	input logic                  bus_ack,
	input logic                  bus_req,
	input logic                  nmi_n,
	input logic                  nmi_en,
	input logic                  dma_start,
	input logic                  dst_we,
	input logic [`DK_RAM_AW-1:0] dst_addr
);

	// Rule failures so far
	int   fail_cnt = 0;
	logic last_wr;

	// Final byte of the copy going into object RAM
	assign last_wr = dst_we && (dst_addr == `DK_RAM_AW'(`DK_DMA_LEN - 1));

	// ================================================
	// CPU strobes
	// ================================================
	a_no_access_on_ack: assert property (@(posedge clk_24576m) disable iff (reset)
		bus_ack |-> !(cpu_rd || cpu_wr))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("CPU access while bus_ack high");
		end

	a_no_overlap: assert property (@(posedge clk_24576m) disable iff (reset)
		!(cpu_rd && cpu_wr))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Read and write strobes overlap");
		end

	// NMI only with its enable bit set
	a_nmi_enabled: assert property (@(posedge clk_24576m) disable iff (reset)
		!nmi_n |-> nmi_en)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("nmi_n low with NMI disabled");
		end

	// ================================================
	// Bus request over one copy
	// ================================================
	a_req_start: assert property (@(posedge clk_24576m) disable iff (reset)
		dma_start && !bus_req |=> bus_req)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("bus_req missing after DMA start");
		end

	a_req_hold: assert property (@(posedge clk_24576m) disable iff (reset)
		bus_req && !last_wr |=> bus_req)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("bus_req dropped mid copy");
		end

	a_req_end: assert property (@(posedge clk_24576m) disable iff (reset)
		last_wr |=> !bus_req)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("bus_req held after last write");
		end

endmodule

bind dk_bus_top dk_bus_asserts u_asserts (
	.clk_24576m, .reset, .cpu_rd, .cpu_wr, .bus_ack, .bus_req, .nmi_n,
	.nmi_en(u_adec.latch[`DK_LATCH_NMI_EN]), .dma_start,
	.dst_we(dma_bus.dst_we), .dst_addr(dma_bus.dst_addr)
);

// ==== verif/dk_bus_tb.sv ====
/*
  Testbench for the CPU bus subsystem. Plays the CPU with one-cycle
  strobes, models the ROM, answers the DMA bus request and checks every
  read against a reference model of the memory map.
*/
`timescale 1ns/1ns
`include "dk_bus_consts.svh"

module dk_bus_tb
	import dk_bus_pkg::*;
();

	// Tests take about 5000 cycles
	localparam int cycle_limit = 20000;

	logic                  clk_24576m, reset;
	logic [15:0]           cpu_addr;
	logic [7:0]            cpu_wdata;
	logic                  cpu_rd, cpu_wr, bus_ack, v_blank, dkjr;
	logic [4:0]            sw_p1, sw_p2;
	logic [2:0]            sw_sys;
	logic [7:0]            dip_sw, rom_data;
	logic [`DK_RAM_AW-1:0] obj_addr;
	logic [7:0]            cpu_rdata, obj_data;
	logic [15:0]           rom_addr;
	logic                  bus_req, nmi_n, flip_n, two_player_sel;
	logic [1:0]            pal_bank;

	integer     seed;
	int         cycles;
	logic [7:0] shadow [3][1024];
	logic [7:0] latch_model;
	logic [7:0] exp_q [$];

	// ROM model, low address byte scrambled
	assign rom_data = rom_addr[7:0] ^ 8'h5A;

	dk_bus_top i_dut (.*);

	initial begin
		clk_24576m = 1'b0;
		forever #2 clk_24576m = ~clk_24576m;
	end

	// ================================================
	// Reference model
	// ================================================
	// 0..2 for RAM1..RAM3, 3 elsewhere
	function automatic int ram_index(input logic [15:0] a);
		if (a >= `DK_RAM1_BASE && a < `DK_RAM1_BASE + 16'h0400)
			return 0;
		if (a >= `DK_RAM2_BASE && a < `DK_RAM2_BASE + 16'h0400)
			return 1;
		if (a >= `DK_RAM3_BASE && a < `DK_RAM3_BASE + 16'h0400)
			return 2;
		return 3;
	endfunction

	function automatic logic [15:0] ram_base(input int r);
		case (r)
			0: return `DK_RAM1_BASE;
			1: return `DK_RAM2_BASE;
			default: return `DK_RAM3_BASE;
		endcase
	endfunction

	// Junior board swaps pages 2/6 and 5/9, cycles 3 -> B -> 7 -> 3
	function automatic logic [15:0] ref_rom_addr(input logic [15:0] a, input logic jr);
		cpu_addr_u  v;
		logic [4:0] pg;
		v.raw = a;
		pg = v.rom_page.page;
		if (jr) begin
			case (v.rom_page.page)
				5'h02: pg = 5'h06;
				5'h06: pg = 5'h02;
				5'h05: pg = 5'h09;
				5'h09: pg = 5'h05;
				5'h03: pg = 5'h0B;
				5'h0B: pg = 5'h07;
				5'h07: pg = 5'h03;
				default: ;
			endcase
		end
		v.rom_page.page = pg;
		return v.raw;
	endfunction

	function automatic logic [7:0] dk_ref_read(input logic [15:0] a);
		logic [15:0] phys;
		logic [7:0]  b;
		int          r;
		phys = ref_rom_addr(a, dkjr);
		r = ram_index(a);
		b = 8'h00;
		if (a <= `DK_ROM_TOP)
			b = phys[7:0] ^ 8'h5A;
		else if (r < 3)
			b = shadow[r][a[9:0]];
		else if (a[15:7] == (`DK_IN_SW1 >> 7))
			b = {3'b000, sw_p1};
		else if (a[15:7] == (`DK_IN_SW2 >> 7))
			b = {3'b000, sw_p2};
		else if (a[15:7] == (`DK_IN_SW3 >> 7)) begin
			// Coin, start 2, start 1
			b[7] = sw_sys[2];
			b[3] = sw_sys[1];
			b[2] = sw_sys[0];
		end else if (a[15:7] == (`DK_IN_DIP >> 7))
			b = dip_sw;
		return b;
	endfunction

	// ================================================
	// Checks and CPU bus model
	// ================================================
	task automatic check_val(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_latch_outputs();
		check_val("flip_n", flip_n, !latch_model[`DK_LATCH_FLIP]);
		check_val("two_player_sel", two_player_sel, latch_model[`DK_LATCH_2PSL]);
		check_val("pal_bank", pal_bank, latch_model[`DK_LATCH_PAL +: 2]);
	endtask

	// Both bus tasks start and end on a falling edge
	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		int r;
		r = ram_index(a);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_wr    = 1'b1;
		if (r < 3)
			shadow[r][a[9:0]] = d;
		if ((a & 16'hFFF8) == `DK_LATCH_BASE)
			latch_model[a[2:0]] = d[0];
		@(negedge clk_24576m);
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] a);
		cpu_addr = a;
		cpu_rd   = 1'b1;
		exp_q.push_back(dk_ref_read(a));
		@(negedge clk_24576m);
		cpu_rd = 1'b0;
	endtask

	// Read data compare, mid cycle after the strobe
	initial begin
		logic [7:0] exp_b;
		forever begin
			@(posedge clk_24576m);
			if (cpu_rd) begin
				if (cpu_addr <= `DK_ROM_TOP)
					check_val("rom_addr", rom_addr, ref_rom_addr(cpu_addr, dkjr));
				@(negedge clk_24576m);
				if (exp_q.size() == 0) begin
					$display("Read data returned with no read outstanding");
					$display("TESTBENCH FAILED");
					$fatal(1, "Empty expect queue");
				end
				exp_b = exp_q.pop_front();
				check_val("cpu_rdata", cpu_rdata, exp_b);
			end
		end
	end

	// Cycle limit and bound rule failures
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk_24576m);
			cycles++;
			if (i_dut.u_asserts.fail_cnt != 0) begin
				$display("A bus rule assertion failed");
				$display("TESTBENCH FAILED");
				$fatal(1, "Assertion failure");
			end else if (cycles >= cycle_limit) begin
				$display("Run did not finish within %0d cycles", cycle_limit);
				$display("TESTBENCH FAILED");
				$fatal(1, "Timeout");
			end
		end
	end

	// ================================================
	// Stimulus
	// ================================================
	initial begin
		logic [15:0] a;
		logic [2:0]  off;
		int          r;
		seed        = 32'h5548;
		latch_model = 8'h00;
		reset       = 1'b1;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		cpu_rd      = 1'b0;
		cpu_wr      = 1'b0;
		bus_ack     = 1'b0;
		v_blank     = 1'b0;
		dkjr        = 1'b0;
		sw_p1       = '0;
		sw_p2       = '0;
		sw_sys      = '0;
		dip_sw      = '0;
		obj_addr    = '0;
		repeat (10) @(negedge clk_24576m);
		reset = 1'b0;
		check_val("bus_req", bus_req, 1'b0);
		check_val("nmi_n", nmi_n, 1'b1);
		check_latch_outputs();

		// Fill every work RAM, then random traffic
		for (r = 0; r < 3; r++)
			for (int i = 0; i < 1024; i++)
				cpu_write(ram_base(r) + 16'(i), 8'($random(seed)));
		repeat (400) begin
			r = {$random(seed)} % 3;
			a = ram_base(r) + 16'($random(seed) & 32'h3FF);
			if ($random(seed) & 1)
				cpu_write(a, 8'($random(seed)));
			else
				cpu_read(a);
		end

		// Every ROM page, plain and junior board
		for (int jr = 0; jr < 2; jr++) begin
			dkjr = jr[0];
			for (int pg = 0; pg < 12; pg++)
				cpu_read({pg[4:0], 11'($random(seed))});
		end
		dkjr = 1'b0;

		// Switch bytes and unmapped reads
		repeat (16) begin
			sw_p1  = 5'($random(seed));
			sw_p2  = 5'($random(seed));
			sw_sys = 3'($random(seed));
			dip_sw = 8'($random(seed));
			cpu_read(`DK_IN_SW1 + 16'($random(seed) & 32'h7F));
			cpu_read(`DK_IN_SW2 + 16'($random(seed) & 32'h7F));
			cpu_read(`DK_IN_SW3 + 16'($random(seed) & 32'h7F));
			cpu_read(`DK_IN_DIP + 16'($random(seed) & 32'h7F));
			case ({$random(seed)} % 3)
				0: a = `DK_RAM2_BASE + 16'h0400 + 16'({$random(seed)} % 32'h800);
				1: a = `DK_RAM3_BASE + 16'h0400 + 16'({$random(seed)} % 32'h800);
				default: a = `DK_IN_DIP + 16'h0080 + 16'({$random(seed)} % 32'h8200);
			endcase
			cpu_read(a);
		end

		// Latch bits, DMA bit left alone
		repeat (24) begin
			off = 3'($random(seed));
			if (off == `DK_LATCH_DMA)
				off = `DK_LATCH_NMI_EN;
			cpu_write(`DK_LATCH_BASE + 16'(off), 8'($random(seed)));
			check_latch_outputs();
		end

		// NMI on v_blank rise, cleared with the enable
		cpu_write(`DK_LATCH_BASE + `DK_LATCH_NMI_EN, 8'h01);
		check_val("nmi_n", nmi_n, 1'b1);
		v_blank = 1'b1;
		@(negedge clk_24576m);
		check_val("nmi_n", nmi_n, 1'b0);
		v_blank = 1'b0;
		@(negedge clk_24576m);
		check_val("nmi_n", nmi_n, 1'b0);
		cpu_write(`DK_LATCH_BASE + `DK_LATCH_NMI_EN, 8'h00);
		check_val("nmi_n", nmi_n, 1'b1);
		v_blank = 1'b1;
		@(negedge clk_24576m);
		check_val("nmi_n", nmi_n, 1'b1);
		v_blank = 1'b0;

		// ================================================
		// Sprite DMA with random grant drops
		// ================================================
		cpu_write(`DK_LATCH_BASE + `DK_LATCH_DMA, 8'h01);
		check_val("bus_req", bus_req, 1'b1);
		while (bus_req) begin
			bus_ack = ({$random(seed)} % 4) != 0;
			@(negedge clk_24576m);
		end
		bus_ack = 1'b0;
		for (int i = 0; i < `DK_DMA_LEN; i++) begin
			obj_addr = `DK_RAM_AW'(i);
			@(negedge clk_24576m);
			check_val("obj_data", obj_data, shadow[2][i]);
		end

		// DMA bit already set, no new copy
		cpu_write(`DK_LATCH_BASE + `DK_LATCH_DMA, 8'h01);
		repeat (4) begin
			check_val("bus_req", bus_req, 1'b0);
			@(negedge clk_24576m);
		end

		while (exp_q.size() != 0)
			@(negedge clk_24576m);
		if (i_dut.u_asserts.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Bus rule assertions failed %0d times", i_dut.u_asserts.fail_cnt);
			$display("TESTBENCH FAILED");
			$fatal(1, "Assertion failures");
		end
	end

endmodule
